//--- cw_converter.sv
`timescale 1ns/1ps
`default_nettype none

module cw_converter (
    input  wire                       core_clock,
    input  wire                       core_reset,

    input  wire                       stb_i,
    input  wire                       we_i,
    input  wire [wb_pkg::ADDR_W-1:0]  adr_i,
    input  wire [wb_pkg::DATA_W-1:0]  wdata_i,
    input  wire [wb_pkg::SEL_W-1:0]   sel_i,
    output logic [wb_pkg::DATA_W-1:0] rdata_o,
    output logic                      ack_o,
    output logic                      err_o,

    output logic                      cw_req_o,
    output logic                      cw_dir_o,
    output logic [wb_pkg::DATA_W-1:0] cw_io_o,
    input  wire [wb_pkg::DATA_W-1:0]  cw_io_i,
    input  wire                       cw_ack_i,
    input  wire                       cw_err_i
);

    typedef enum logic [2:0] {
        IDLE,
        CMD,
        ADDR,
        DATA,
        WAIT,
        DONE
    } state_e;

    state_e                    state;
    wb_pkg::cw_op_e            op;
    logic                      resp_err;
    logic [wb_pkg::DATA_W-1:0] cmd_word;

    assign op = we_i ? wb_pkg::CW_WRITE : wb_pkg::CW_READ;

    // Opcode, byte selects, four zero bits, top address byte
    assign cmd_word = {op, sel_i, 4'b0000, adr_i[wb_pkg::ADDR_W-1:16]};

    always_ff @(posedge core_clock) begin
        if (core_reset) begin
            state    <= IDLE;
            resp_err <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (stb_i) begin
                        state <= CMD;
                    end
                end
                CMD: state <= ADDR;
                ADDR: state <= we_i ? DATA : WAIT;
                DATA: state <= WAIT;
                WAIT: begin
                    if (cw_ack_i || cw_err_i) begin
                        resp_err <= cw_err_i;
                        state    <= DONE;
                    end
                end
                DONE: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge core_clock) begin
        if (state == WAIT && cw_ack_i && !we_i) begin
            rdata_o <= cw_io_i;
        end
    end

    always_comb begin
        case (state)
            CMD:     cw_io_o = cmd_word;
            ADDR:    cw_io_o = adr_i[15:0];
            DATA:    cw_io_o = wdata_i;
            default: cw_io_o = '0;
        endcase
    end

    // Request spans the outbound words and the wait, drops in DONE
    assign cw_req_o = (state == CMD) || (state == ADDR) || (state == DATA) || (state == WAIT);
    assign cw_dir_o = (state == WAIT);
    assign ack_o    = (state == DONE) && !resp_err;
    assign err_o    = (state == DONE) && resp_err;

    // Master holds the access for the whole transfer
    a_stb_held: assert property (@(posedge core_clock) disable iff (core_reset)
        (state != IDLE && state != DONE) |-> stb_i);

endmodule

`default_nettype wire

//--- interconnect_trace.txt
# kind(0 single, 1 starts with next line, 2 irq pulse) master(0 host, 1 core) we embed
# addr wdata sel exp_err exp_data (all hex, exp_data checked on read acks only)
0 0 1 0 7ffe10 1234 3 0 0000
0 0 0 0 7ffe10 0000 3 0 1234
0 0 1 0 7ffe10 ab00 2 0 0000
0 0 0 0 7ffe10 0000 3 0 ab34
0 1 1 0 7fffff 5a5a 3 0 0000
0 1 1 0 7fffff 00cd 1 0 0000
0 1 0 0 7fffff 0000 3 0 5acd
0 0 1 0 001000 beef 3 0 0000
0 0 0 0 001000 0000 3 0 beef
0 0 1 0 001000 0077 1 0 0000
0 1 0 0 001000 0000 3 0 be77
0 1 1 0 3a5504 c0de 3 0 0000
0 1 0 0 3a5504 0000 3 0 c0de
0 0 1 0 f00010 1111 3 1 0000
0 1 0 0 ffff00 0000 3 1 0000
0 0 1 1 800020 4321 3 0 0000
0 1 0 1 100020 0000 3 0 4321
0 1 1 1 1001ff 9876 3 0 0000
0 0 0 1 8001ff 0000 3 0 9876
0 0 0 1 001000 0000 3 1 0000
0 1 1 1 7ffe10 5555 3 1 0000
1 0 1 0 7ffe40 aaaa 3 0 0000
0 1 1 0 002000 bbbb 3 0 0000
1 0 0 0 002000 0000 3 0 bbbb
0 1 0 0 7ffe40 0000 3 0 aaaa
2 0 0 0 000000 0000 0 0 0000

//--- iram.sv
`timescale 1ns/1ps
`default_nettype none

module iram #(
    parameter int IRAM_DEPTH = 512
) (
    input  wire                           core_clock,
    input  wire [$clog2(IRAM_DEPTH)-1:0]  addr_i,
    input  wire [wb_pkg::DATA_W-1:0]      wdata_i,
    input  wire [wb_pkg::SEL_W-1:0]       sel_i,
    input  wire                           we_i,
    output logic [wb_pkg::DATA_W-1:0]     rdata_o
);

    logic [wb_pkg::DATA_W-1:0] mem [IRAM_DEPTH];

    always_ff @(posedge core_clock) begin
        // One write enable per byte lane
        for (int i = 0; i < wb_pkg::SEL_W; i++) begin
            if (we_i && sel_i[i]) begin
                mem[addr_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
            end
        end
        rdata_o <= mem[addr_i];
    end

endmodule

`default_nettype wire

//--- map_pkg.sv
`default_nettype none

package map_pkg;

    // RAM window when the tile runs with an external core
    localparam logic [wb_pkg::ADDR_W-1:0] NE_IRAM_BASE = 24'h7ffe00;

    // Embed mode windows, both aliased onto the same RAM
    localparam logic [wb_pkg::ADDR_W-1:0] E_PROG_BASE = 24'h800000;
    localparam logic [wb_pkg::ADDR_W-1:0] E_MEM_BASE  = 24'h100000;

    // Window size in words
    localparam logic [wb_pkg::ADDR_W-1:0] IRAM_SIZE = 24'h000200;

    typedef enum logic [1:0] {
        TGT_CW,
        TGT_IRAM,
        TGT_NONE
    } target_e;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the interconnect testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_top -f sources.f -o tb_sim || exit 1
out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -qx "No errors" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

//--- sources.f
wb_pkg.sv
map_pkg.sv
wb_if.sv
wb_arbiter.sv
wb_interconnect.sv
iram.sv
cw_converter.sv
wb_interconnect_top.sv
tb_checker.sv
tb_top.sv

//--- tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker #(
    parameter int SYNC_STAGES = 2
) (
    input  wire                       core_clock,
    input  wire                       core_reset,
    input  wire                       host_cyc_i,
    input  wire                       host_ack_i,
    input  wire                       host_err_i,
    input  wire [wb_pkg::DATA_W-1:0]  host_dat_i,
    input  wire                       core_ack_i,
    input  wire                       core_err_i,
    input  wire [wb_pkg::DATA_W-1:0]  core_dat_i,
    input  wire                       ext_irq_i,
    input  wire                       inner_irq_i,
    input  wire                       cw_req_i,
    input  wire                       cw_dir_i,
    input  wire                       host_exp_err_i,
    input  wire                       host_exp_rd_i,
    input  wire [wb_pkg::DATA_W-1:0]  host_exp_dat_i,
    input  wire                       core_exp_err_i,
    input  wire                       core_exp_rd_i,
    input  wire [wb_pkg::DATA_W-1:0]  core_exp_dat_i,
    output int                        check_count_o,
    output int                        mismatch_count_o
);

    // Cycles since reset, and the cycle of the latest ext_irq_i sample
    int   cycle_count;
    int   irq_cycle;
    logic irq_exp;
    logic reset_d;

    task automatic compare_value(input string name, input logic [15:0] got,
                                 input logic [15:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            mismatch_count_o++;
        end
    endtask

    // Sampled on the rising edge, before any register of this edge updates
    always @(posedge core_clock) begin
        if (core_reset) begin
            reset_d          <= 1'b1;
            cycle_count      = 0;
            irq_cycle        = -1;
            check_count_o    = 0;
            mismatch_count_o = 0;
        end else begin
            reset_d <= 1'b0;
            if (reset_d) begin
                compare_value("ack/err/cw_req_o/cw_dir_o/inner_irq_o after reset",
                              16'({host_ack_i, host_err_i, core_ack_i, core_err_i,
                                   cw_req_i, cw_dir_i, inner_irq_i}), 16'h0000);
            end

            // Pulse shows up exactly SYNC_STAGES cycles after it was sampled
            irq_exp = (irq_cycle >= 0) && (cycle_count - irq_cycle == SYNC_STAGES);
            compare_value("inner_irq_o", 16'(inner_irq_i), 16'(irq_exp));
            if (ext_irq_i) begin
                irq_cycle = cycle_count;
            end
            cycle_count++;

            if (host_ack_i || host_err_i) begin
                check_count_o++;
                compare_value("host_err_o", 16'(host_err_i), 16'(host_exp_err_i));
                if (host_ack_i && host_exp_rd_i) begin
                    compare_value("host_dat_o", host_dat_i, host_exp_dat_i);
                end
            end

            if (core_ack_i || core_err_i) begin
                check_count_o++;
                compare_value("core_err_o", 16'(core_err_i), 16'(core_exp_err_i));
                if (core_ack_i && core_exp_rd_i) begin
                    compare_value("core_dat_o", core_dat_i, core_exp_dat_i);
                end
                // Host has priority, so it never waits behind a core access
                if (host_cyc_i) begin
                    $display("Core access completed while the host still held its bus cycle");
                    mismatch_count_o++;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;

    localparam int SYNC_STAGES = 2;
    localparam int MAX_LINES   = 64;
    localparam int TIMEOUT     = 200;

    logic                      core_clock;
    logic                      core_reset;
    logic                      embed_mode_i;
    logic                      ext_irq_i;
    logic                      inner_irq_o;
    logic                      host_cyc_i;
    logic                      host_stb_i;
    logic                      host_we_i;
    logic [wb_pkg::ADDR_W-1:0] host_adr_i;
    logic [wb_pkg::DATA_W-1:0] host_dat_i;
    logic [wb_pkg::SEL_W-1:0]  host_sel_i;
    logic [wb_pkg::DATA_W-1:0] host_dat_o;
    logic                      host_ack_o;
    logic                      host_err_o;
    logic                      core_cyc_i;
    logic                      core_stb_i;
    logic                      core_we_i;
    logic [wb_pkg::ADDR_W-1:0] core_adr_i;
    logic [wb_pkg::DATA_W-1:0] core_dat_i;
    logic [wb_pkg::SEL_W-1:0]  core_sel_i;
    logic [wb_pkg::DATA_W-1:0] core_dat_o;
    logic                      core_ack_o;
    logic                      core_err_o;
    logic                      cw_req_o;
    logic                      cw_dir_o;
    logic [wb_pkg::DATA_W-1:0] cw_io_o;
    logic [wb_pkg::DATA_W-1:0] cw_io_i;
    logic                      cw_ack_i;
    logic                      cw_err_i;

    // Expected outcome of the access each master has in flight
    logic                      host_exp_err;
    logic                      host_exp_rd;
    logic [wb_pkg::DATA_W-1:0] host_exp_dat;
    logic                      core_exp_err;
    logic                      core_exp_rd;
    logic [wb_pkg::DATA_W-1:0] core_exp_dat;

    // Trace columns
    logic [31:0] t_kind [MAX_LINES];
    logic [31:0] t_master [MAX_LINES];
    logic [31:0] t_we [MAX_LINES];
    logic [31:0] t_embed [MAX_LINES];
    logic [31:0] t_addr [MAX_LINES];
    logic [31:0] t_wdata [MAX_LINES];
    logic [31:0] t_sel [MAX_LINES];
    logic [31:0] t_err [MAX_LINES];
    logic [31:0] t_data [MAX_LINES];

    int          line_count;
    int          access_count;
    int          fail_count;
    int          check_count;
    int          mismatch_count;
    integer      seed = 32'hbd555040;
    logic [15:0] remote_mem [logic [23:0]];

    wb_interconnect_top #(
        .SYNC_STAGES (SYNC_STAGES)
    ) dut (.*);

    tb_checker #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_checker (
        .core_clock       (core_clock),
        .core_reset       (core_reset),
        .host_cyc_i       (host_cyc_i),
        .host_ack_i       (host_ack_o),
        .host_err_i       (host_err_o),
        .host_dat_i       (host_dat_o),
        .core_ack_i       (core_ack_o),
        .core_err_i       (core_err_o),
        .core_dat_i       (core_dat_o),
        .ext_irq_i        (ext_irq_i),
        .inner_irq_i      (inner_irq_o),
        .cw_req_i         (cw_req_o),
        .cw_dir_i         (cw_dir_o),
        .host_exp_err_i   (host_exp_err),
        .host_exp_rd_i    (host_exp_rd),
        .host_exp_dat_i   (host_exp_dat),
        .core_exp_err_i   (core_exp_err),
        .core_exp_rd_i    (core_exp_rd),
        .core_exp_dat_i   (core_exp_dat),
        .check_count_o    (check_count),
        .mismatch_count_o (mismatch_count)
    );

    initial core_clock = 1'b0;
    always #2 core_clock = ~core_clock;

    function automatic logic [15:0] remote_fill(input logic [23:0] addr);
        return addr[15:0] ^ {addr[23:16], addr[7:0]} ^ 16'h3c3c;
    endfunction

    task automatic load_trace();
        int    fd;
        int    n;
        string line;
        line_count   = 0;
        access_count = 0;
        fd = $fopen("interconnect_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open interconnect_trace.txt");
            fail_count++;
            return;
        end
        while (!$feof(fd) && line_count < MAX_LINES) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != 8'h23) begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                            t_kind[line_count], t_master[line_count], t_we[line_count],
                            t_embed[line_count], t_addr[line_count], t_wdata[line_count],
                            t_sel[line_count], t_err[line_count], t_data[line_count]);
                if (n == 9) begin
                    if (t_kind[line_count] != 2) begin
                        access_count++;
                    end
                    line_count++;
                end
            end
        end
        $fclose(fd);
    endtask

    // Starts on a falling edge, returns on the falling edge that drops cyc
    task automatic run_access(input int idx);
        int   waited;
        logic done;
        waited = 0;
        done   = 1'b0;
        if (t_master[idx] == 0) begin
            host_exp_err = t_err[idx][0];
            host_exp_rd  = !t_we[idx][0];
            host_exp_dat = t_data[idx][15:0];
            host_we_i    = t_we[idx][0];
            host_adr_i   = t_addr[idx][23:0];
            host_dat_i   = t_wdata[idx][15:0];
            host_sel_i   = t_sel[idx][1:0];
            host_cyc_i   = 1'b1;
            host_stb_i   = 1'b1;
        end else begin
            core_exp_err = t_err[idx][0];
            core_exp_rd  = !t_we[idx][0];
            core_exp_dat = t_data[idx][15:0];
            core_we_i    = t_we[idx][0];
            core_adr_i   = t_addr[idx][23:0];
            core_dat_i   = t_wdata[idx][15:0];
            core_sel_i   = t_sel[idx][1:0];
            core_cyc_i   = 1'b1;
            core_stb_i   = 1'b1;
        end
        while (!done && waited < TIMEOUT) begin
            @(negedge core_clock);
            waited++;
            if (t_master[idx] == 0) begin
                done = host_ack_o || host_err_o;
            end else begin
                done = core_ack_o || core_err_o;
            end
        end
        if (!done) begin
            $display("Trace line %0d got neither ack nor err within %0d cycles", idx, TIMEOUT);
            fail_count++;
        end
        // Hold through the rising edge that carries the response
        @(negedge core_clock);
        if (t_master[idx] == 0) begin
            host_cyc_i = 1'b0;
            host_stb_i = 1'b0;
        end else begin
            core_cyc_i = 1'b0;
            core_stb_i = 1'b0;
        end
    endtask

    task automatic pulse_irq();
        ext_irq_i = 1'b1;
        @(negedge core_clock);
        ext_irq_i = 1'b0;
        repeat (SYNC_STAGES + 2) @(negedge core_clock);
    endtask

    // Remote cw target, collects the outbound words then answers after a random delay
    initial begin : remote_model
        logic [15:0]    words [3];
        int             cnt;
        int             delay;
        logic [23:0]    addr;
        logic [15:0]    value;
        wb_pkg::cw_op_e op;
        cnt = 0;
        forever begin
            @(negedge core_clock);
            if (cw_req_o && !cw_dir_o) begin
                if (cnt < 3) begin
                    words[cnt] = cw_io_o;
                end
                cnt++;
            end else if (cw_req_o && cw_dir_o) begin
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) @(negedge core_clock);
                op   = wb_pkg::cw_op_e'(words[0][15:14]);
                addr = {words[0][7:0], words[1]};
                value = remote_mem.exists(addr) ? remote_mem[addr] : remote_fill(addr);
                if (addr >= 24'hf00000) begin
                    cw_err_i = 1'b1;
                end else if (op == wb_pkg::CW_WRITE) begin
                    if (words[0][12]) value[7:0] = words[2][7:0];
                    if (words[0][13]) value[15:8] = words[2][15:8];
                    remote_mem[addr] = value;
                    cw_ack_i = 1'b1;
                end else begin
                    cw_io_i  = value;
                    cw_ack_i = 1'b1;
                end
                @(negedge core_clock);
                cw_ack_i = 1'b0;
                cw_err_i = 1'b0;
                cw_io_i  = '0;
                cnt      = 0;
            end
        end
    end

    initial begin
        int i;
        core_reset   = 1'b1;
        embed_mode_i = 1'b0;
        ext_irq_i    = 1'b0;
        host_cyc_i   = 1'b0;
        host_stb_i   = 1'b0;
        host_we_i    = 1'b0;
        host_adr_i   = '0;
        host_dat_i   = '0;
        host_sel_i   = '0;
        core_cyc_i   = 1'b0;
        core_stb_i   = 1'b0;
        core_we_i    = 1'b0;
        core_adr_i   = '0;
        core_dat_i   = '0;
        core_sel_i   = '0;
        cw_io_i      = '0;
        cw_ack_i     = 1'b0;
        cw_err_i     = 1'b0;
        host_exp_err = 1'b0;
        host_exp_rd  = 1'b0;
        host_exp_dat = '0;
        core_exp_err = 1'b0;
        core_exp_rd  = 1'b0;
        core_exp_dat = '0;
        fail_count   = 0;
        load_trace();
        repeat (2) @(negedge core_clock);
        core_reset = 1'b0;
        i = 0;
        while (i < line_count) begin
            @(negedge core_clock);
            embed_mode_i = t_embed[i][0];
            if (t_kind[i] == 2) begin
                pulse_irq();
                i++;
            end else if (t_kind[i] == 1 && i + 1 < line_count) begin
                // Both masters raise cyc on the same edge
                fork
                    run_access(i);
                    run_access(i + 1);
                join
                i += 2;
            end else begin
                run_access(i);
                i++;
            end
        end
        repeat (4) @(negedge core_clock);
        if (check_count != access_count || access_count == 0) begin
            $display("Only %0d of %0d trace accesses completed", check_count, access_count);
            fail_count++;
        end
        $display("checks %0d, mismatches %0d, other failures %0d",
                 check_count, mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- wb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter (
    input  wire                       core_clock,
    input  wire                       core_reset,

    input  wire                       host_cyc_i,
    input  wire                       host_stb_i,
    input  wire                       host_we_i,
    input  wire [wb_pkg::ADDR_W-1:0]  host_adr_i,
    input  wire [wb_pkg::DATA_W-1:0]  host_dat_i,
    input  wire [wb_pkg::SEL_W-1:0]   host_sel_i,
    output logic [wb_pkg::DATA_W-1:0] host_dat_o,
    output logic                      host_ack_o,
    output logic                      host_err_o,

    input  wire                       core_cyc_i,
    input  wire                       core_stb_i,
    input  wire                       core_we_i,
    input  wire [wb_pkg::ADDR_W-1:0]  core_adr_i,
    input  wire [wb_pkg::DATA_W-1:0]  core_dat_i,
    input  wire [wb_pkg::SEL_W-1:0]   core_sel_i,
    output logic [wb_pkg::DATA_W-1:0] core_dat_o,
    output logic                      core_ack_o,
    output logic                      core_err_o,

    wb_if.master                      bus_o
);

    typedef enum logic [1:0] {
        IDLE,
        GRANT_HOST,
        GRANT_CORE
    } grant_e;

    grant_e grant;

    wb_if m0_bus ();
    wb_if m1_bus ();

    assign m0_bus.cyc   = host_cyc_i;
    assign m0_bus.stb   = host_stb_i;
    assign m0_bus.we    = host_we_i;
    assign m0_bus.adr   = host_adr_i;
    assign m0_bus.dat_w = host_dat_i;
    assign m0_bus.sel   = host_sel_i;

    assign m1_bus.cyc   = core_cyc_i;
    assign m1_bus.stb   = core_stb_i;
    assign m1_bus.we    = core_we_i;
    assign m1_bus.adr   = core_adr_i;
    assign m1_bus.dat_w = core_dat_i;
    assign m1_bus.sel   = core_sel_i;

    // Host wins a tie, grant held until the owner drops cyc
    always_ff @(posedge core_clock) begin
        if (core_reset) begin
            grant <= IDLE;
        end else begin
            case (grant)
                IDLE: begin
                    if (m0_bus.cyc) begin
                        grant <= GRANT_HOST;
                    end else if (m1_bus.cyc) begin
                        grant <= GRANT_CORE;
                    end
                end
                GRANT_HOST: begin
                    if (!m0_bus.cyc) begin
                        grant <= IDLE;
                    end
                end
                GRANT_CORE: begin
                    if (!m1_bus.cyc) begin
                        grant <= IDLE;
                    end
                end
                default: grant <= IDLE;
            endcase
        end
    end

    always_comb begin
        bus_o.cyc   = 1'b0;
        bus_o.stb   = 1'b0;
        bus_o.we    = 1'b0;
        bus_o.adr   = '0;
        bus_o.dat_w = '0;
        bus_o.sel   = '0;
        case (grant)
            GRANT_HOST: begin
                bus_o.cyc   = m0_bus.cyc;
                bus_o.stb   = m0_bus.stb;
                bus_o.we    = m0_bus.we;
                bus_o.adr   = m0_bus.adr;
                bus_o.dat_w = m0_bus.dat_w;
                bus_o.sel   = m0_bus.sel;
            end
            GRANT_CORE: begin
                bus_o.cyc   = m1_bus.cyc;
                bus_o.stb   = m1_bus.stb;
                bus_o.we    = m1_bus.we;
                bus_o.adr   = m1_bus.adr;
                bus_o.dat_w = m1_bus.dat_w;
                bus_o.sel   = m1_bus.sel;
            end
            default: ;
        endcase
    end

    // Responses go back only to the owner of the grant
    assign m0_bus.ack   = (grant == GRANT_HOST) && bus_o.ack;
    assign m0_bus.err   = (grant == GRANT_HOST) && bus_o.err;
    assign m0_bus.dat_r = (grant == GRANT_HOST) ? bus_o.dat_r : '0;
    assign m1_bus.ack   = (grant == GRANT_CORE) && bus_o.ack;
    assign m1_bus.err   = (grant == GRANT_CORE) && bus_o.err;
    assign m1_bus.dat_r = (grant == GRANT_CORE) ? bus_o.dat_r : '0;

    assign host_ack_o = m0_bus.ack;
    assign host_err_o = m0_bus.err;
    assign host_dat_o = m0_bus.dat_r;
    assign core_ack_o = m1_bus.ack;
    assign core_err_o = m1_bus.err;
    assign core_dat_o = m1_bus.dat_r;

    // A master only sees a response while it owns the bus with cyc raised
    a_host_ack_granted: assert property (@(posedge core_clock) disable iff (core_reset)
        (host_ack_o || host_err_o) |-> (host_cyc_i && grant == GRANT_HOST));
    a_core_ack_granted: assert property (@(posedge core_clock) disable iff (core_reset)
        (core_ack_o || core_err_o) |-> (core_cyc_i && grant == GRANT_CORE));

endmodule

`default_nettype wire

//--- wb_if.sv
`timescale 1ns/1ps
`default_nettype none

interface wb_if;

    logic                      cyc;
    logic                      stb;
    logic                      we;
    logic [wb_pkg::ADDR_W-1:0] adr;
    logic [wb_pkg::DATA_W-1:0] dat_w;
    logic [wb_pkg::SEL_W-1:0]  sel;
    logic [wb_pkg::DATA_W-1:0] dat_r;
    logic                      ack;
    logic                      err;

    modport master (
        output cyc, stb, we, adr, dat_w, sel,
        input  dat_r, ack, err
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w, sel,
        output dat_r, ack, err
    );

endinterface

`default_nettype wire

//--- wb_interconnect.sv
`timescale 1ns/1ps
`default_nettype none

module wb_interconnect #(
    parameter int IRAM_DEPTH  = 512,
    parameter int SYNC_STAGES = 2
) (
    input  wire                          core_clock,
    input  wire                          core_reset,
    input  wire                          embed_mode_i,
    input  wire                          ext_irq_i,
    output logic                         inner_irq_o,

    wb_if.slave                          bus_i,

    output logic [$clog2(IRAM_DEPTH)-1:0] iram_addr_o,
    output logic [wb_pkg::DATA_W-1:0]    iram_wdata_o,
    output logic [wb_pkg::SEL_W-1:0]     iram_sel_o,
    output logic                         iram_we_o,
    input  wire [wb_pkg::DATA_W-1:0]     iram_rdata_i,

    output logic                         cw_stb_o,
    output logic                         cw_we_o,
    output logic [wb_pkg::ADDR_W-1:0]    cw_adr_o,
    output logic [wb_pkg::DATA_W-1:0]    cw_wdata_o,
    output logic [wb_pkg::SEL_W-1:0]     cw_sel_o,
    input  wire [wb_pkg::DATA_W-1:0]     cw_rdata_i,
    input  wire                          cw_ack_i,
    input  wire                          cw_err_i
);

    localparam int IRAM_AW = $clog2(IRAM_DEPTH);

    map_pkg::target_e tgt;
    logic             access;
    logic             in_ne;
    logic             in_prog;
    logic             in_mem;
    logic             iram_ack;
    logic [SYNC_STAGES-1:0] irq_sync;

    assign access = bus_i.cyc && bus_i.stb;

    assign in_ne   = (bus_i.adr >= map_pkg::NE_IRAM_BASE) &&
                     (bus_i.adr < map_pkg::NE_IRAM_BASE + map_pkg::IRAM_SIZE);
    assign in_prog = (bus_i.adr >= map_pkg::E_PROG_BASE) &&
                     (bus_i.adr < map_pkg::E_PROG_BASE + map_pkg::IRAM_SIZE);
    assign in_mem  = (bus_i.adr >= map_pkg::E_MEM_BASE) &&
                     (bus_i.adr < map_pkg::E_MEM_BASE + map_pkg::IRAM_SIZE);

    always_comb begin
        if (!embed_mode_i) begin
            tgt = in_ne ? map_pkg::TGT_IRAM : map_pkg::TGT_CW;
        end else begin
            tgt = (in_prog || in_mem) ? map_pkg::TGT_IRAM : map_pkg::TGT_NONE;
        end
    end

    // Both embed windows index the RAM by the low address bits
    assign iram_addr_o  = bus_i.adr[IRAM_AW-1:0];
    assign iram_wdata_o = bus_i.dat_w;
    assign iram_sel_o   = bus_i.sel;
    assign iram_we_o    = access && bus_i.we && (tgt == map_pkg::TGT_IRAM) && !iram_ack;

    always_ff @(posedge core_clock) begin
        if (core_reset) begin
            iram_ack <= 1'b0;
        end else begin
            iram_ack <= access && (tgt == map_pkg::TGT_IRAM) && !iram_ack;
        end
    end

    assign cw_stb_o   = access && (tgt == map_pkg::TGT_CW);
    assign cw_we_o    = bus_i.we;
    assign cw_adr_o   = bus_i.adr;
    assign cw_wdata_o = bus_i.dat_w;
    assign cw_sel_o   = bus_i.sel;

    always_comb begin
        bus_i.ack   = 1'b0;
        bus_i.err   = 1'b0;
        bus_i.dat_r = '0;
        case (tgt)
            map_pkg::TGT_IRAM: begin
                bus_i.ack   = iram_ack;
                bus_i.dat_r = iram_rdata_i;
            end
            map_pkg::TGT_CW: begin
                bus_i.ack   = cw_ack_i;
                bus_i.err   = cw_err_i;
                bus_i.dat_r = cw_rdata_i;
            end
            // Unmapped address fails in the same cycle
            default: bus_i.err = access;
        endcase
    end

    always_ff @(posedge core_clock) begin
        if (core_reset) begin
            irq_sync <= '0;
        end else begin
            irq_sync <= {irq_sync[SYNC_STAGES-2:0], ext_irq_i};
        end
    end

    assign inner_irq_o = irq_sync[SYNC_STAGES-1];

    a_ack_err_exclusive: assert property (@(posedge core_clock) disable iff (core_reset)
        !(bus_i.ack && bus_i.err));

endmodule

`default_nettype wire

//--- wb_interconnect_top.sv
`timescale 1ns/1ps
`default_nettype none

module wb_interconnect_top #(
    parameter int IRAM_DEPTH  = 512,
    parameter int SYNC_STAGES = 2
) (
    input  wire                       core_clock,
    input  wire                       core_reset,
    input  wire                       embed_mode_i,
    input  wire                       ext_irq_i,
    output logic                      inner_irq_o,

    input  wire                       host_cyc_i,
    input  wire                       host_stb_i,
    input  wire                       host_we_i,
    input  wire [wb_pkg::ADDR_W-1:0]  host_adr_i,
    input  wire [wb_pkg::DATA_W-1:0]  host_dat_i,
    input  wire [wb_pkg::SEL_W-1:0]   host_sel_i,
    output logic [wb_pkg::DATA_W-1:0] host_dat_o,
    output logic                      host_ack_o,
    output logic                      host_err_o,

    input  wire                       core_cyc_i,
    input  wire                       core_stb_i,
    input  wire                       core_we_i,
    input  wire [wb_pkg::ADDR_W-1:0]  core_adr_i,
    input  wire [wb_pkg::DATA_W-1:0]  core_dat_i,
    input  wire [wb_pkg::SEL_W-1:0]   core_sel_i,
    output logic [wb_pkg::DATA_W-1:0] core_dat_o,
    output logic                      core_ack_o,
    output logic                      core_err_o,

    output logic                      cw_req_o,
    output logic                      cw_dir_o,
    output logic [wb_pkg::DATA_W-1:0] cw_io_o,
    input  wire [wb_pkg::DATA_W-1:0]  cw_io_i,
    input  wire                       cw_ack_i,
    input  wire                       cw_err_i
);

    localparam int IRAM_AW = $clog2(IRAM_DEPTH);

    logic [IRAM_AW-1:0]        iram_addr;
    logic [wb_pkg::DATA_W-1:0] iram_wdata;
    logic [wb_pkg::SEL_W-1:0]  iram_sel;
    logic                      iram_we;
    logic [wb_pkg::DATA_W-1:0] iram_rdata;

    logic                      cw_stb;
    logic                      cw_we;
    logic [wb_pkg::ADDR_W-1:0] cw_adr;
    logic [wb_pkg::DATA_W-1:0] cw_wdata;
    logic [wb_pkg::SEL_W-1:0]  cw_sel;
    logic [wb_pkg::DATA_W-1:0] cw_rdata;
    logic                      cw_ack;
    logic                      cw_err;

    wb_if arb_bus ();

    wb_arbiter u_arbiter (
        .core_clock (core_clock),
        .core_reset (core_reset),
        .host_cyc_i (host_cyc_i),
        .host_stb_i (host_stb_i),
        .host_we_i  (host_we_i),
        .host_adr_i (host_adr_i),
        .host_dat_i (host_dat_i),
        .host_sel_i (host_sel_i),
        .host_dat_o (host_dat_o),
        .host_ack_o (host_ack_o),
        .host_err_o (host_err_o),
        .core_cyc_i (core_cyc_i),
        .core_stb_i (core_stb_i),
        .core_we_i  (core_we_i),
        .core_adr_i (core_adr_i),
        .core_dat_i (core_dat_i),
        .core_sel_i (core_sel_i),
        .core_dat_o (core_dat_o),
        .core_ack_o (core_ack_o),
        .core_err_o (core_err_o),
        .bus_o      (arb_bus.master)
    );

    wb_interconnect #(
        .IRAM_DEPTH  (IRAM_DEPTH),
        .SYNC_STAGES (SYNC_STAGES)
    ) u_interconnect (
        .core_clock   (core_clock),
        .core_reset   (core_reset),
        .embed_mode_i (embed_mode_i),
        .ext_irq_i    (ext_irq_i),
        .inner_irq_o  (inner_irq_o),
        .bus_i        (arb_bus.slave),
        .iram_addr_o  (iram_addr),
        .iram_wdata_o (iram_wdata),
        .iram_sel_o   (iram_sel),
        .iram_we_o    (iram_we),
        .iram_rdata_i (iram_rdata),
        .cw_stb_o     (cw_stb),
        .cw_we_o      (cw_we),
        .cw_adr_o     (cw_adr),
        .cw_wdata_o   (cw_wdata),
        .cw_sel_o     (cw_sel),
        .cw_rdata_i   (cw_rdata),
        .cw_ack_i     (cw_ack),
        .cw_err_i     (cw_err)
    );

    iram #(
        .IRAM_DEPTH (IRAM_DEPTH)
    ) u_iram (
        .core_clock (core_clock),
        .addr_i     (iram_addr),
        .wdata_i    (iram_wdata),
        .sel_i      (iram_sel),
        .we_i       (iram_we),
        .rdata_o    (iram_rdata)
    );

    cw_converter u_cw_converter (
        .core_clock (core_clock),
        .core_reset (core_reset),
        .stb_i      (cw_stb),
        .we_i       (cw_we),
        .adr_i      (cw_adr),
        .wdata_i    (cw_wdata),
        .sel_i      (cw_sel),
        .rdata_o    (cw_rdata),
        .ack_o      (cw_ack),
        .err_o      (cw_err),
        .cw_req_o   (cw_req_o),
        .cw_dir_o   (cw_dir_o),
        .cw_io_o    (cw_io_o),
        .cw_io_i    (cw_io_i),
        .cw_ack_i   (cw_ack_i),
        .cw_err_i   (cw_err_i)
    );

endmodule

`default_nettype wire

//--- wb_pkg.sv
`default_nettype none

package wb_pkg;

    // Bus widths shared by both masters and all targets
    localparam int ADDR_W = 24;
    localparam int DATA_W = 16;
    localparam int SEL_W  = 2;

    // cw command opcodes, sent in the top two bits of the command word
    typedef enum logic [1:0] {
        CW_READ  = 2'b01,
        CW_WRITE = 2'b10
    } cw_op_e;

endpackage

`default_nettype wire
